/* hw/aes_cfg.svh */
// AES engine configuration
// Key-length encodings, round counts and the Wishbone register map

`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// CONFIG bit 0 encodings
`define AES_KEYLEN_128 1'b0
`define AES_KEYLEN_256 1'b1

// Number of rounds per key length
`define AES_ROUNDS_128 4'd10
`define AES_ROUNDS_256 4'd14

// Word addresses on the bus
`define AES_ADR_CTRL    6'h00
`define AES_ADR_CONFIG  6'h01
`define AES_ADR_STATUS  6'h02
`define AES_ADR_KEY0    6'h08
`define AES_ADR_BLOCK0  6'h10
`define AES_ADR_RESULT0 6'h14

`endif

/* hw/aes_encipher_block.sv */
// AES encipher round engine
// Initial, main and final rounds over a four-word state, with SubBytes
// done one word per cycle through a shared S-box

`include "aes_cfg.svh"

module aes_encipher_block (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             zeroize,
  input  logic             next,
  input  aes_pkg::keylen_t keylen,
  output logic [3:0]       round,
  input  aes_pkg::block_t  round_key,
  output aes_pkg::word_t   sboxw,
  input  aes_pkg::word_t   new_sboxw,
  input  aes_pkg::block_t  block,
  output aes_pkg::block_t  new_block,
  output logic             ready
);

  typedef enum logic [1:0] {st_idle, st_init, st_sbox, st_main} state_t;

  state_t           state;
  aes_pkg::word_t   st_w [0:3];
  logic [3:0]       round_ctr;
  logic [1:0]       word_ctr;
  logic [3:0]       num_rounds;
  aes_pkg::update_t upd;
  aes_pkg::block_t  sr_block;
  aes_pkg::block_t  next_block;

  // ----------------------------------------------------------------------
  // Round functions
  // ----------------------------------------------------------------------
  function automatic logic [7:0] gm2(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  // One column times the fixed MixColumns matrix, rows are rotations
  function automatic aes_pkg::word_t mixw(input aes_pkg::word_t w);
    logic [7:0] b [0:3];
    aes_pkg::word_t m;
    for (int i = 0; i < 4; i++)
      b[i] = w[31 - 8*i -: 8];
    for (int i = 0; i < 4; i++)
      m[31 - 8*i -: 8] = gm2(b[i]) ^ gm2(b[(i+1)%4]) ^ b[(i+1)%4]
                         ^ b[(i+2)%4] ^ b[(i+3)%4];
    return m;
  endfunction

  function automatic aes_pkg::block_t mixcolumns(input aes_pkg::block_t d);
    aes_pkg::block_t m;
    for (int c = 0; c < 4; c++)
      m[127 - 32*c -: 32] = mixw(d[127 - 32*c -: 32]);
    return m;
  endfunction

  // Row r rotates left by r columns
  function automatic aes_pkg::block_t shiftrows(input aes_pkg::block_t d);
    aes_pkg::block_t s;
    for (int c = 0; c < 4; c++)
      for (int r = 0; r < 4; r++)
        s[127 - 32*c - 8*r -: 8] = d[127 - 32*((c + r) % 4) - 8*r -: 8];
    return s;
  endfunction

  assign round     = round_ctr;
  assign new_block = {st_w[0], st_w[1], st_w[2], st_w[3]};
  assign sboxw     = st_w[word_ctr];
  assign sr_block  = shiftrows(new_block);

  // ----------------------------------------------------------------------
  // Update kind and datapath
  // ----------------------------------------------------------------------
  always_comb
  begin
    num_rounds = (keylen == aes_pkg::key_256) ? `AES_ROUNDS_256 : `AES_ROUNDS_128;
    case (state)
      st_init: upd = aes_pkg::update_init;
      st_sbox: upd = aes_pkg::update_sbox;
      // Last round skips MixColumns
      st_main: upd = (round_ctr < num_rounds) ? aes_pkg::update_main
                                             : aes_pkg::update_final;
      default: upd = aes_pkg::update_none;
    endcase

    case (upd)
      aes_pkg::update_init:  next_block = block ^ round_key;
      aes_pkg::update_main:  next_block = mixcolumns(sr_block) ^ round_key;
      aes_pkg::update_final: next_block = sr_block ^ round_key;
      default:               next_block = new_block;
    endcase
  end

  // ----------------------------------------------------------------------
  // State, counters and FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      st_w      <= '{default: '0};
      state     <= st_idle;
      round_ctr <= 4'd0;
      word_ctr  <= 2'd0;
      ready     <= 1'b1;
    end
    else if (zeroize)
    begin
      st_w      <= '{default: '0};
      state     <= st_idle;
      round_ctr <= 4'd0;
      word_ctr  <= 2'd0;
      ready     <= 1'b1;
    end
    else
    begin
      // SubBytes replaces one word, the round updates replace all four
      if (upd == aes_pkg::update_sbox)
        st_w[word_ctr] <= new_sboxw;
      else if (upd != aes_pkg::update_none)
        for (int i = 0; i < 4; i++)
          st_w[i] <= next_block[127 - 32*i -: 32];

      case (state)
        st_idle:
          if (next)
          begin
            round_ctr <= 4'd0;
            ready     <= 1'b0;
            state     <= st_init;
          end
        st_init:
        begin
          round_ctr <= round_ctr + 4'd1;
          word_ctr  <= 2'd0;
          state     <= st_sbox;
        end
        st_sbox:
        begin
          // Counter wraps back to word 0 for the next round
          word_ctr <= word_ctr + 2'd1;
          if (word_ctr == 2'd3)
            state <= st_main;
        end
        default:
        begin
          round_ctr <= round_ctr + 4'd1;
          if (upd == aes_pkg::update_final)
          begin
            ready <= 1'b1;
            state <= st_idle;
          end
          else
            state <= st_sbox;
        end
      endcase
    end
  end

endmodule

/* hw/aes_key_mem.sv */
// AES key expansion for 128- and 256-bit keys
// Builds one round key per cycle into a 15-entry memory and serves the
// key for the round the engine asks for

`include "aes_cfg.svh"

module aes_key_mem (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             zeroize,
  input  logic             init,
  input  aes_pkg::keylen_t keylen,
  input  logic [255:0]     key,
  input  logic [3:0]       round,
  output aes_pkg::block_t  round_key,
  output logic             ready,
  output aes_pkg::word_t   sboxw,
  input  aes_pkg::word_t   new_sboxw
);

  // One entry per round, rounds 0 to 14
  aes_pkg::block_t key_mem [0:14];

  // The two latest round keys, 256-bit schedule needs both
  aes_pkg::block_t  prev_key0;
  aes_pkg::block_t  prev_key1;
  logic [7:0]       rcon;
  logic [3:0]       round_ctr;
  logic             busy;

  aes_pkg::update_t upd;
  aes_pkg::block_t  new_key;
  logic [3:0]       num_rounds;

  // Doubling in GF(2^8), steps rcon
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  assign ready     = !busy;
  assign round_key = key_mem[round];
  // Last word of the newest key goes through SubWord
  assign sboxw     = prev_key1[31:0];

  // ----------------------------------------------------------------------
  // Next round key
  // ----------------------------------------------------------------------
  always_comb
  begin : gen_key
    aes_pkg::block_t src;
    aes_pkg::word_t  temp;
    aes_pkg::word_t  k0, k1, k2, k3;

    num_rounds = (keylen == aes_pkg::key_256) ? `AES_ROUNDS_256 : `AES_ROUNDS_128;

    upd = aes_pkg::update_none;
    if (busy)
    begin
      // Raw key halves first, then the schedule proper
      if (round_ctr == 4'd0 || (keylen == aes_pkg::key_256 && round_ctr == 4'd1))
        upd = aes_pkg::update_init;
      else if (keylen == aes_pkg::key_128 || !round_ctr[0])
        upd = aes_pkg::update_main;
      else
        upd = aes_pkg::update_sbox;
    end

    // W[i-Nk] comes from two keys back for 256-bit, one key back for 128
    src  = (keylen == aes_pkg::key_256) ? prev_key0 : prev_key1;
    // RotWord after SubWord equals SubWord after RotWord
    temp = (upd == aes_pkg::update_main) ?
           ({new_sboxw[23:0], new_sboxw[31:24]} ^ {rcon, 24'h0}) : new_sboxw;
    k0 = src[127:96] ^ temp;
    k1 = src[95:64]  ^ k0;
    k2 = src[63:32]  ^ k1;
    k3 = src[31:0]   ^ k2;

    if (upd == aes_pkg::update_init)
      new_key = round_ctr[0] ? key[127:0] : key[255:128];
    else
      new_key = {k0, k1, k2, k3};
  end

  // ----------------------------------------------------------------------
  // Schedule state
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      prev_key0 <= '0;
      prev_key1 <= '0;
      rcon      <= 8'h01;
      round_ctr <= 4'd0;
      busy      <= 1'b0;
    end
    else if (zeroize)
    begin
      prev_key0 <= '0;
      prev_key1 <= '0;
      rcon      <= 8'h01;
      round_ctr <= 4'd0;
      busy      <= 1'b0;
    end
    else if (!busy)
    begin
      if (init)
      begin
        busy      <= 1'b1;
        round_ctr <= 4'd0;
        rcon      <= 8'h01;
      end
    end
    else
    begin
      round_ctr <= round_ctr + 4'd1;
      if (round_ctr == num_rounds)
        busy <= 1'b0;
      if (upd == aes_pkg::update_main)
        rcon <= xtime(rcon);

      // 256-bit round 0 parks the upper key half in the older slot
      if (keylen == aes_pkg::key_256 && round_ctr == 4'd0)
        prev_key0 <= new_key;
      else
      begin
        prev_key1 <= new_key;
        if (keylen == aes_pkg::key_256 && round_ctr != 4'd1)
          prev_key0 <= prev_key1;
      end
    end
  end

  // Round-key array
  always_ff @(posedge clk)
  begin
    if (busy)
      key_mem[round_ctr] <= new_key;
  end

endmodule

/* hw/aes_pkg.sv */
// AES engine types
// Words, blocks, key length and the register update kinds

`include "aes_cfg.svh"

package aes_pkg;

  // One column of the state
  typedef logic [31:0] word_t;

  // Full state or one round key
  typedef logic [127:0] block_t;

  typedef enum logic {
    key_128 = `AES_KEYLEN_128,
    key_256 = `AES_KEYLEN_256
  } keylen_t;

  // What a block register takes on the coming edge
  typedef enum logic [2:0] {
    update_none  = 3'd0,
    update_init  = 3'd1,
    update_sbox  = 3'd2,
    update_main  = 3'd3,
    update_final = 3'd4
  } update_t;

endpackage

/* hw/aes_sbox.sv */
// AES forward S-box
// Substitutes all four bytes of one 32-bit word in a single cycle

module aes_sbox (
  input  aes_pkg::word_t in,
  output aes_pkg::word_t out
);

  // ----------------------------------------------------------------------
  // Lookup table, entry 0x00 in the top byte
  // ----------------------------------------------------------------------
  localparam logic [2047:0] SBOX_TABLE = {
    256'h637c777bf26b6fc53001672bfed7ab76ca82c97dfa5947f0add4a2af9ca472c0,
    256'hb7fd9326363ff7cc34a5e5f171d8311504c723c31896059a071280e2eb27b275,
    256'h09832c1a1b6e5aa0523bd6b329e32f8453d100ed20fcb15b6acbbe394a4c58cf,
    256'hd0efaafb434d338545f9027f503c9fa851a3408f929d38f5bcb6da2110fff3d2,
    256'hcd0c13ec5f974417c4a77e3d645d197360814fdc222a908846eeb814de5e0bdb,
    256'he0323a0a4906245cc2d3ac629195e479e7c8376d8dd54ea96c56f4ea657aae08,
    256'hba78252e1ca6b4c6e8dd741f4bbd8b8a703eb5664803f60e613557b986c11d9e,
    256'he1f8981169d98e949b1e87e9ce5528df8ca1890dbfe6426841992d0fb054bb16
  };

  // Byte b sits at bit offset (255 - b) * 8
  function automatic logic [7:0] sub_byte(input logic [7:0] b);
    return SBOX_TABLE[(255 - b) * 8 +: 8];
  endfunction

  // ----------------------------------------------------------------------
  // Four parallel lookups
  // ----------------------------------------------------------------------
  assign out = {sub_byte(in[31:24]),
                sub_byte(in[23:16]),
                sub_byte(in[15:8]),
                sub_byte(in[7:0])};

endmodule

/* hw/aes_top.sv */
// AES encipher subsystem top
// Register block, key expansion and round engine around one shared S-box

module aes_top (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           wb_cyc,
  input  logic           wb_stb,
  input  logic           wb_we,
  input  logic [5:0]     wb_adr,
  input  aes_pkg::word_t wb_dat_w,
  output aes_pkg::word_t wb_dat_r,
  output logic           wb_ack
);

  logic             init, next, zeroize;
  logic             key_ready, core_ready;
  aes_pkg::keylen_t keylen;
  logic [255:0]     key;
  logic [3:0]       round;
  aes_pkg::block_t  block, result, round_key;
  aes_pkg::word_t   key_sboxw, enc_sboxw, sbox_in, sbox_out;

  // S-box belongs to key expansion until all round keys are written
  assign sbox_in = key_ready ? enc_sboxw : key_sboxw;

  aes_wb_regs u_regs (
    .clk, .reset_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r,
    .wb_ack, .init, .next, .zeroize, .keylen, .key, .block, .result,
    .key_ready, .core_ready
  );

  aes_key_mem u_key_mem (
    .clk, .reset_n, .zeroize, .init, .keylen, .key, .round, .round_key,
    .ready(key_ready), .sboxw(key_sboxw), .new_sboxw(sbox_out)
  );

  aes_encipher_block u_enc (
    .clk, .reset_n, .zeroize, .next, .keylen, .round, .round_key,
    .sboxw(enc_sboxw), .new_sboxw(sbox_out), .block, .new_block(result),
    .ready(core_ready)
  );

  aes_sbox u_sbox (
    .in(sbox_in),
    .out(sbox_out)
  );

endmodule

/* hw/aes_wb_regs.sv */
// Wishbone classic register block for the AES engine
// Holds key, block and config, returns result and status, and issues
// the init, next and zeroize pulses

`include "aes_cfg.svh"

module aes_wb_regs (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [5:0]       wb_adr,
  input  aes_pkg::word_t   wb_dat_w,
  output aes_pkg::word_t   wb_dat_r,
  output logic             wb_ack,
  output logic             init,
  output logic             next,
  output logic             zeroize,
  output aes_pkg::keylen_t keylen,
  output logic [255:0]     key,
  output aes_pkg::block_t  block,
  input  aes_pkg::block_t  result,
  input  logic             key_ready,
  input  logic             core_ready
);

  logic           req, wr, ctrl_wr, ready;
  logic           in_key, in_block, in_result;
  logic [2:0]     key_idx;
  logic [1:0]     blk_idx, res_idx;
  logic           valid, key_loaded, core_ready_d;
  aes_pkg::word_t rd_data;

  // New request only when ack is not already out
  assign req     = wb_cyc && wb_stb && !wb_ack;
  assign wr      = req && wb_we;
  assign ctrl_wr = wr && wb_adr == `AES_ADR_CTRL;
  assign ready   = key_ready && core_ready;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  assign in_key    = wb_adr >= `AES_ADR_KEY0 && wb_adr < `AES_ADR_KEY0 + 6'd8;
  assign in_block  = wb_adr >= `AES_ADR_BLOCK0 && wb_adr < `AES_ADR_BLOCK0 + 6'd4;
  assign in_result = wb_adr >= `AES_ADR_RESULT0 && wb_adr < `AES_ADR_RESULT0 + 6'd4;
  assign key_idx   = 3'(wb_adr - `AES_ADR_KEY0);
  assign blk_idx   = 2'(wb_adr - `AES_ADR_BLOCK0);
  assign res_idx   = 2'(wb_adr - `AES_ADR_RESULT0);

  // CTRL, KEY and unmapped words read zero
  always_comb
  begin
    rd_data = '0;
    if (wb_adr == `AES_ADR_CONFIG)
      rd_data = {31'h0, keylen};
    else if (wb_adr == `AES_ADR_STATUS)
      rd_data = {30'h0, valid, ready};
    else if (in_block)
      rd_data = block[(3 - blk_idx) * 32 +: 32];
    else if (in_result)
      rd_data = result[(3 - res_idx) * 32 +: 32];
  end

  // ----------------------------------------------------------------------
  // Registers and command pulses
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wb_ack       <= 1'b0;
      wb_dat_r     <= '0;
      init         <= 1'b0;
      next         <= 1'b0;
      zeroize      <= 1'b0;
      keylen       <= aes_pkg::key_128;
      key          <= '0;
      block        <= '0;
      valid        <= 1'b0;
      key_loaded   <= 1'b0;
      core_ready_d <= 1'b1;
    end
    else
    begin
      wb_ack       <= req;
      wb_dat_r     <= req ? rd_data : '0;
      core_ready_d <= core_ready;
      // Commands are dropped while the core is busy
      init    <= ctrl_wr && wb_dat_w[0] && ready;
      next    <= ctrl_wr && wb_dat_w[1] && ready && key_loaded;
      zeroize <= ctrl_wr && wb_dat_w[2];

      if (wr && wb_adr == `AES_ADR_CONFIG)
        keylen <= aes_pkg::keylen_t'(wb_dat_w[0]);

      // CONFIG survives zeroize
      if (zeroize)
      begin
        key          <= '0;
        block        <= '0;
        valid        <= 1'b0;
        key_loaded   <= 1'b0;
        // Engine returns to ready here, which is not a finished result
        core_ready_d <= 1'b1;
      end
      else
      begin
        if (wr && in_key)
          key[(7 - key_idx) * 32 +: 32] <= wb_dat_w;
        if (wr && in_block)
          block[(3 - blk_idx) * 32 +: 32] <= wb_dat_w;
        if (init)
          key_loaded <= 1'b1;
        // Result is valid from the end of encipher until the next command
        if (init || next)
          valid <= 1'b0;
        else if (core_ready && !core_ready_d)
          valid <= 1'b1;
      end
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the AES testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_aes
out=$(./obj_dir/Vtb_aes)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF "PASS: all tests"; then
  exit 0
fi
exit 1

/* sim.f */
+incdir+hw
hw/aes_pkg.sv
hw/aes_sbox.sv
hw/aes_key_mem.sv
hw/aes_encipher_block.sv
hw/aes_wb_regs.sv
hw/aes_top.sv
tests/aes_checker.sv
tests/tb_aes.sv

/* tests/aes_checker.sv */
// Bus monitor and scoreboard for the AES testbench
// Compares acknowledged STATUS and RESULT reads with the pattern file

`include "aes_cfg.svh"

module aes_checker #(
  parameter int NUM_VECTORS = 1
) (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [5:0]  wb_adr,
  input  logic [31:0] wb_dat_r,
  input  logic        wb_ack,
  output int          value_errors,
  output int          bus_errors,
  output int          result_reads
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [255:0] patterns [0:NUM_VECTORS*5-1];
  logic [5:0]   req_adr;
  logic         req_we;
  int           wait_cycles;
  // Latest STATUS value seen, compared once the results start
  logic [31:0]  last_status;
  // Model of the key-loaded flag, drives the expected valid bit
  logic         key_loaded;

  initial
    $readmemh("tests/aes_patterns.hex", patterns);

  task automatic check_read(input logic [5:0] adr, input logic [31:0] data);
    int           vec;
    int           word;
    logic [7:0]   op;
    logic [31:0]  exp_status;
    logic [127:0] exp_block;
    logic [31:0]  exp_word;
    vec  = result_reads / 4;
    word = int'(adr - `AES_ADR_RESULT0);
    if (adr == `AES_ADR_STATUS)
      last_status = data;
    else if (adr >= `AES_ADR_RESULT0 && word < 4)
    begin
      if (vec >= NUM_VECTORS)
      begin
        $display("result read beyond the last vector");
        bus_errors++;
      end
      else
      begin
        // First result word closes the vector's status check
        if (word == 0)
        begin
          op = patterns[vec*5][7:0];
          if (op == 8'h01)
            key_loaded = 1'b1;
          else if (op == 8'h03)
            key_loaded = 1'b0;
          exp_status = {30'h0, key_loaded, 1'b1};
          if (last_status !== exp_status)
          begin
            $display("error vector %0d status: expected %08h, got %08h",
                     vec, exp_status, last_status);
            value_errors++;
          end
        end
        exp_block = patterns[vec*5 + 4][127:0];
        exp_word  = exp_block[127 - 32*word -: 32];
        if (data !== exp_word)
        begin
          $display("error vector %0d result word %0d: expected %08h, got %08h",
                   vec, word, exp_word, data);
          value_errors++;
        end
      end
      result_reads++;
    end
  endtask

  // ------------------------------------------------------------------
  // Sample on the rising edge, inputs settle at the falling edge
  // ------------------------------------------------------------------
  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      value_errors = 0;
      bus_errors   = 0;
      result_reads = 0;
      wait_cycles  = 0;
      key_loaded   = 1'b0;
      last_status  = '0;
    end
    else if (wb_ack)
    begin
      if (wait_cycles == 0)
      begin
        $display("ack arrived with no request pending");
        bus_errors++;
      end
      else if (wait_cycles > 1)
      begin
        $display("ack came %0d cycles after strobe, one expected", wait_cycles);
        bus_errors++;
      end
      wait_cycles = 0;
      if (!req_we)
        check_read(req_adr, wb_dat_r);
    end
    else if (wb_cyc && wb_stb)
    begin
      if (wait_cycles == 0)
      begin
        req_adr = wb_adr;
        req_we  = wb_we;
      end
      wait_cycles++;
    end
  end

endmodule

/* tests/aes_patterns.hex */
// Fields: op (1 key+init+encipher, 2 next, 3 zeroize), key length (0 = 128, 1 = 256),
// 256-bit key (128-bit keys in the upper half), plaintext, expected result
// FIPS-197 AES-128 and AES-256 examples
01 0 000102030405060708090a0b0c0d0e0f00000000000000000000000000000000 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
01 1 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
// SP 800-38A AES-256 key, then a next without re-init
01 1 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
02 1 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870
// Back to a 128-bit key, FIPS-197 appendix B, then two next commands
01 0 2b7e151628aed2a6abf7158809cf4f3c00000000000000000000000000000000 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
02 0 2b7e151628aed2a6abf7158809cf4f3c00000000000000000000000000000000 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
02 0 2b7e151628aed2a6abf7158809cf4f3c00000000000000000000000000000000 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
// Zeroize, then a next with no key loaded
03 0 0000000000000000000000000000000000000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000
02 0 0000000000000000000000000000000000000000000000000000000000000000 f69f2445df4f9b17ad2b417be66c3710 00000000000000000000000000000000

/* tests/tb_aes.sv */
// Testbench for the AES encipher subsystem
// Replays the pattern file over Wishbone; the checker module does the comparing

`include "aes_cfg.svh"

module tb_aes;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_VECTORS = 9;
  // Words per vector in the pattern file
  localparam int FIELDS      = 5;
  localparam int POLL_LIMIT  = 100;
  // 300 cycles per vector plus margin
  localparam int WATCHDOG_NS = (NUM_VECTORS * 300 + 100) * 10;

  logic        clk;
  logic        reset_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [5:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  logic [255:0] patterns [0:NUM_VECTORS*FIELDS-1];
  logic [31:0]  rand_state;
  int           run_errors;
  int           value_errors;
  int           bus_errors;
  int           result_reads;

  aes_top u_dut (
    .clk, .reset_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

  aes_checker #(.NUM_VECTORS(NUM_VECTORS)) u_checker (
    .clk, .reset_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_r, .wb_ack,
    .value_errors, .bus_errors, .result_reads
  );

  // --------------------------------------------------------------------
  // Clock and watchdog
  // --------------------------------------------------------------------
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: run still going after %0d ns", WATCHDOG_NS);
    report_counts();
    $display("FAIL: see errors above");
    $finish;
  end

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_counts();
    $display("summary: %0d value errors, %0d bus errors, %0d run errors",
             value_errors, bus_errors, run_errors);
  endtask

  // 0 to 3 idle cycles between bus cycles
  task automatic insert_gap();
    rand_state = xorshift32(rand_state);
    repeat (rand_state[1:0]) @(negedge clk);
  endtask

  // Classic cycle, held until ack
  task automatic write_reg(input logic [5:0] adr, input logic [31:0] data);
    insert_gap();
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    @(negedge clk);
    while (!wb_ack)
      @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_reg(input logic [5:0] adr, output logic [31:0] data);
    insert_gap();
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (!wb_ack)
      @(negedge clk);
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // Poll STATUS until the ready bit is set
  task automatic wait_ready();
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[0] && polls < POLL_LIMIT)
    begin
      read_reg(`AES_ADR_STATUS, status);
      polls++;
    end
    if (!status[0])
    begin
      $display("core never reported ready after %0d status reads", polls);
      run_errors++;
    end
  endtask

  task automatic load_block(input logic [127:0] pt);
    for (int i = 0; i < 4; i++)
      write_reg(`AES_ADR_BLOCK0 + 6'(i), pt[127 - 32*i -: 32]);
  endtask

  // One line of the pattern file: command, wait, then status and result
  task automatic run_vector(input int idx);
    logic [7:0]   op;
    logic         keylen;
    logic [255:0] key;
    logic [127:0] pt;
    logic [31:0]  rdata;
    op     = patterns[idx*FIELDS][7:0];
    keylen = patterns[idx*FIELDS + 1][0];
    key    = patterns[idx*FIELDS + 2];
    pt     = patterns[idx*FIELDS + 3][127:0];
    case (op)
      8'h01:
      begin
        write_reg(`AES_ADR_CONFIG, {31'h0, keylen});
        for (int i = 0; i < 8; i++)
          write_reg(`AES_ADR_KEY0 + 6'(i), key[255 - 32*i -: 32]);
        write_reg(`AES_ADR_CTRL, 32'h1);
        wait_ready();
        load_block(pt);
        write_reg(`AES_ADR_CTRL, 32'h2);
      end
      8'h02:
      begin
        load_block(pt);
        write_reg(`AES_ADR_CTRL, 32'h2);
      end
      8'h03:
        write_reg(`AES_ADR_CTRL, 32'h4);
      default:
      begin
        $display("vector %0d has unknown op code %0h", idx, op);
        run_errors++;
      end
    endcase
    wait_ready();
    read_reg(`AES_ADR_STATUS, rdata);
    for (int i = 0; i < 4; i++)
      read_reg(`AES_ADR_RESULT0 + 6'(i), rdata);
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------
  initial
  begin
    reset_n    = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    rand_state = 32'd23;
    run_errors = 0;
    $readmemh("tests/aes_patterns.hex", patterns);

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    for (int v = 0; v < NUM_VECTORS; v++)
      run_vector(v);

    // Checker sees the last ack one edge later
    repeat (2) @(posedge clk);
    if (result_reads != NUM_VECTORS * 4)
    begin
      $display("checker saw %0d result reads instead of %0d", result_reads,
               NUM_VECTORS * 4);
      run_errors++;
    end

    report_counts();
    if (value_errors + bus_errors + run_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule
